// File: filelist.f
+incdir+bench
logic/buf_cfg_pkg.sv
logic/buf_if_pkg.sv
logic/chan_fifo.sv
logic/space_tracker.sv
logic/latency_bridge.sv
logic/chan_unit.sv
logic/buf_ctrl.sv
bench/tb_clkgen.sv
bench/tb_buf_ctrl.sv

// File: run.sh
#!/bin/sh
# Compile the stream buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_buf_ctrl

out=$(./obj_dir/Vtb_buf_ctrl)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
        exit 0
fi
exit 1

// File: bench/buf_tests.svh
//==========================================================
// Directed tests and stimulus tasks, included in the testbench top
//==========================================================

// Producer beat, waits for wr_ready and transfers on the edge
task automatic push_beat(input int ch, input logic [buf_cfg_pkg::DATA_W-1:0] d);
        int waits;
        waits    = 0;
        wr.valid = 1'b1;
        wr.ch_id = buf_cfg_pkg::CH_ID_W'(ch);
        wr.data  = d;
        #1;
        while (!wr_ready && waits < 20) begin
                next_cycle();
                waits++;
        end
        require(wr_ready, $sformatf("channel %0d never became ready for a write", ch));
        if (wr_ready) begin
                ref_q[ch].push_back(d);
                if (wr_resv_m[ch] > 0) wr_resv_m[ch]--;          // Write uses reserved space
        end
        next_cycle();
        wr.valid = 1'b0;
endtask

// Consumer pop, waits for rd_valid and checks the head beat
task automatic pop_beat(input int ch);
        int                             waits;
        logic [buf_cfg_pkg::DATA_W-1:0] want;
        waits = 0;
        while (!rd_valid[ch] && waits < 20) begin
                next_cycle();
                waits++;
        end
        require(rd_valid[ch], $sformatf("channel %0d presented no beat to pop", ch));
        if (rd_valid[ch] && ref_q[ch].size() != 0) begin
                rd.drain = 1'b1;
                rd.ch_id = buf_cfg_pkg::CH_ID_W'(ch);
                #1;
                want = ref_q[ch].pop_front();
                compare_value($sformatf("rd_data[ch %0d]", ch), want, rd_data);
                if (dr_resv_m[ch] > 0) dr_resv_m[ch]--;
                next_cycle();
                rd.drain = 1'b0;
        end
endtask

// Reservation requests last one cycle, granted only when they fit
task automatic request_alloc(input int ch, input int size);
        alloc.req   = 1'b1;
        alloc.ch_id = buf_cfg_pkg::CH_ID_W'(ch);
        alloc.size  = buf_cfg_pkg::SIZE_W'(size);
        if (size <= free_expected(ch)) wr_resv_m[ch] += size;
        next_cycle();
        alloc.req = 1'b0;
endtask

task automatic request_drain(input int ch, input int size);
        drain_req[ch].req  = 1'b1;
        drain_req[ch].size = buf_cfg_pkg::SIZE_W'(size);
        if (size <= avail_expected(ch)) dr_resv_m[ch] += size;
        next_cycle();
        drain_req[ch].req = 1'b0;
endtask

//==========================================================
// Directed tests
//==========================================================
task automatic reset_state();
        err_mark = err_cnt;
        compare_value("rd_valid", 0, rd_valid);
        compare_value("dbg_pending", 0, dbg_pending);
        compare_value("dbg_out_valid", 0, dbg_out_valid);
        verify_counts();                                        // Full space, no data
        for (int c = 0; c < buf_cfg_pkg::NUM_CH; c++) begin
                wr.ch_id = buf_cfg_pkg::CH_ID_W'(c);
                #1;
                compare_value($sformatf("wr_ready[id %0d]", c), 1, wr_ready);
        end
        finish_test("reset_state");
endtask

task automatic write_reservation();
        err_mark = err_cnt;
        request_alloc(1, 6);
        compare_value("space_free[1]", 10, space_free[1]);
        request_alloc(1, 11);                                   // Larger than the 10 left
        compare_value("space_free[1]", 10, space_free[1]);
        for (int i = 0; i < 4; i++)
                push_beat(1, $random(seed));
        compare_value("space_free[1]", 10, space_free[1]);      // 4 stored, 2 reserved
        compare_value("data_avail[1]", 4, data_avail[1]);
        verify_counts();
        for (int i = 0; i < 4; i++)
                pop_beat(1);
        finish_test("write_reservation");
endtask

task automatic order_isolation();
        int ch;
        int pick;
        int guard;
        err_mark = err_cnt;
        for (int i = 0; i < 15; i++) begin                      // Never fills one channel
                ch = $unsigned($random(seed)) % buf_cfg_pkg::NUM_CH;
                push_beat(ch, $random(seed));
        end
        guard = 0;
        while (ref_q[0].size() + ref_q[1].size() + ref_q[2].size() != 0 && guard < 60) begin
                pick = -1;
                for (int c = buf_cfg_pkg::NUM_CH - 1; c >= 0; c--)
                        if (rd_valid[c] && ref_q[c].size() != 0) pick = c;
                if (pick >= 0)
                        pop_beat(pick);
                else
                        next_cycle();
                guard++;
        end
        require(ref_q[0].size() + ref_q[1].size() + ref_q[2].size() == 0,
                "interleaved beats were not all returned");
        compare_value("rd_valid", 0, rd_valid);
        verify_counts();
        finish_test("order_isolation");
endtask

task automatic back_pressure();
        logic [buf_cfg_pkg::DATA_W-1:0] held_beat;
        err_mark = err_cnt;
        for (int i = 0; i < buf_cfg_pkg::CH_DEPTH; i++)
                push_beat(2, $random(seed));
        held_beat = $random(seed);
        wr.valid  = 1'b1;                                       // Producer keeps its beat
        wr.data   = held_beat;
        repeat (2) next_cycle();
        compare_value("wr_ready", 0, wr_ready);
        verify_counts();                                        // Nothing entered
        wr.valid = 1'b0;
        pop_beat(2);
        #1;
        compare_value("wr_ready", 1, wr_ready);
        push_beat(2, held_beat);
        for (int i = 0; i < buf_cfg_pkg::CH_DEPTH; i++)
                pop_beat(2);
        compare_value("rd_valid[2]", 0, rd_valid[2]);
        verify_counts();
        finish_test("back_pressure");
endtask

task automatic drain_reservation();
        err_mark = err_cnt;
        for (int i = 0; i < 8; i++)
                push_beat(0, $random(seed));
        request_drain(0, 5);
        compare_value("data_avail[0]", 3, data_avail[0]);
        for (int i = 0; i < 5; i++)
                pop_beat(0);                                    // Consume the reservation
        compare_value("data_avail[0]", 3, data_avail[0]);
        verify_counts();
        for (int i = 0; i < 3; i++)
                pop_beat(0);
        compare_value("rd_valid[0]", 0, rd_valid[0]);
        finish_test("drain_reservation");
endtask

task automatic invalid_id();
        err_mark = err_cnt;
        push_beat(0, $random(seed));                            // Real data on channel 0
        wr.ch_id = 2'd3;
        rd.ch_id = 2'd3;
        #1;
        compare_value("wr_ready", 0, wr_ready);
        compare_value("rd_data", 0, rd_data);
        wr.valid    = 1'b1;
        wr.data     = $random(seed);
        rd.drain    = 1'b1;
        alloc.req   = 1'b1;
        alloc.ch_id = 2'd3;
        alloc.size  = 5'd4;
        next_cycle();
        wr.valid  = 1'b0;
        rd.drain  = 1'b0;
        alloc.req = 1'b0;
        compare_value("dbg_pending", 1, dbg_pending);           // Channel 0 pull in flight
        next_cycle();
        compare_value("dbg_pending", 0, dbg_pending);
        compare_value("dbg_out_valid", 1, dbg_out_valid);       // Beat landed in the bridge
        verify_counts();                                        // No channel was touched
        pop_beat(0);
        compare_value("rd_valid", 0, rd_valid);
        finish_test("invalid_id");
endtask

// File: bench/tb_buf_ctrl.sv
//==========================================================
// Testbench top for the stream buffer controller
// Holds the DUT, the reference model, watchdog and report
//==========================================================

`timescale 1ns/100ps

module tb_buf_ctrl;

        localparam int TEST_CNT    = 6;
        localparam int TEST_CYC    = 100;               // Upper bound per test
        localparam int WATCHDOG_NS = TEST_CNT * TEST_CYC * 10 + 2000;

        logic                                                   clk;
        logic                                                   rst;
        buf_if_pkg::wr_beat_t                                   wr;
        logic                                                   wr_ready;
        buf_if_pkg::alloc_req_t                                 alloc;
        logic [buf_cfg_pkg::NUM_CH-1:0][buf_cfg_pkg::CNT_W-1:0] space_free;
        buf_if_pkg::drain_req_t [buf_cfg_pkg::NUM_CH-1:0]       drain_req;
        logic [buf_cfg_pkg::NUM_CH-1:0][buf_cfg_pkg::CNT_W-1:0] data_avail;
        buf_if_pkg::rd_sel_t                                    rd;
        logic [buf_cfg_pkg::NUM_CH-1:0]                         rd_valid;
        logic [buf_cfg_pkg::DATA_W-1:0]                         rd_data;
        logic [buf_cfg_pkg::NUM_CH-1:0]                         dbg_pending;
        logic [buf_cfg_pkg::NUM_CH-1:0]                         dbg_out_valid;

        //==========================================================
        // Reference model, beats in order plus reservations
        //==========================================================
        logic [buf_cfg_pkg::DATA_W-1:0] ref_q [buf_cfg_pkg::NUM_CH][$];
        int                             wr_resv_m [buf_cfg_pkg::NUM_CH];
        int                             dr_resv_m [buf_cfg_pkg::NUM_CH];
        integer                         seed;
        int                             err_cnt;
        int                             err_mark;       // Errors at test start
        int                             pass_cnt;
        int                             fail_cnt;

        tb_clkgen u_clkgen (.clk(clk), .rst(rst));

        buf_ctrl dut0 (
                .clk(clk), .rst(rst),
                .wr(wr), .wr_ready(wr_ready),
                .alloc(alloc), .space_free(space_free),
                .drain_req(drain_req), .data_avail(data_avail),
                .rd(rd), .rd_valid(rd_valid), .rd_data(rd_data),
                .dbg_pending(dbg_pending), .dbg_out_valid(dbg_out_valid)
        );

        // Inputs change 1 ns after the rising edge
        task automatic next_cycle();
                @(posedge clk);
                #1;
        endtask

        task automatic compare_value(input string name, input logic [31:0] want,
                                     input logic [31:0] got);
                assert (got === want) else begin
                        $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
                        err_cnt++;
                end
        endtask

        task automatic require(input logic cond, input string what);
                assert (cond === 1'b1) else begin
                        $display("At %0t ns: %s", $time, what);
                        err_cnt++;
                end
        endtask

        // Expected counts from the stored beats and reservations
        function automatic int free_expected(input int ch);
                return buf_cfg_pkg::CH_DEPTH - ref_q[ch].size() - wr_resv_m[ch];
        endfunction

        function automatic int avail_expected(input int ch);
                int diff;
                diff = ref_q[ch].size() - dr_resv_m[ch];
                return (diff > 0) ? diff : 0;
        endfunction

        task automatic verify_counts();
                for (int c = 0; c < buf_cfg_pkg::NUM_CH; c++) begin
                        compare_value($sformatf("space_free[%0d]", c), free_expected(c),
                                      space_free[c]);
                        compare_value($sformatf("data_avail[%0d]", c), avail_expected(c),
                                      data_avail[c]);
                end
        endtask

        task automatic finish_test(input string name);
                if (err_cnt == err_mark) begin
                        pass_cnt++;
                        $display("[%0t ns] %s: ok", $time, name);
                end else begin
                        fail_cnt++;
                        $display("[%0t ns] %s: FAILED, %0d errors", $time, name,
                                 err_cnt - err_mark);
                end
        endtask

        `include "buf_tests.svh"

        initial begin : watchdog
                #(WATCHDOG_NS);
                $display("Watchdog expired, tests did not finish within %0d ns", WATCHDOG_NS);
                $display("Simulation failed");
                $finish;
        end

        initial begin : main
                wr        = '0;
                alloc     = '0;
                drain_req = '0;
                rd        = '0;
                seed      = 21;
                err_cnt   = 0;
                err_mark  = 0;
                pass_cnt  = 0;
                fail_cnt  = 0;
                for (int c = 0; c < buf_cfg_pkg::NUM_CH; c++) begin
                        wr_resv_m[c] = 0;
                        dr_resv_m[c] = 0;
                end
                @(negedge rst);
                next_cycle();
                reset_state();
                write_reservation();
                order_isolation();
                back_pressure();
                drain_reservation();
                invalid_id();
                $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
                if (fail_cnt == 0 && err_cnt == 0)
                        $display("Simulation passed");
                else
                        $display("Simulation failed");
                $finish;
        end

endmodule : tb_buf_ctrl

// File: bench/tb_clkgen.sv
//==========================================================
// Testbench clock and reset source, 10 ns clock period
//==========================================================

`timescale 1ns/100ps

module tb_clkgen (
        output logic clk,
        output logic rst
);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;                  // 100 MHz
        end

        // Synchronous reset held over the first two edges
        initial begin
                rst = 1'b1;
                repeat (2) @(posedge clk);
                #1 rst = 1'b0;
        end

endmodule : tb_clkgen

// File: logic/buf_ctrl.sv
//==========================================================
// Multi channel stream buffer top level
// Decodes channel IDs and returns ready and data by ID
//==========================================================

`timescale 1ns/100ps

module buf_ctrl (
        input  logic                                            clk,
        input  logic                                            rst,
        input  buf_if_pkg::wr_beat_t                            wr,
        output logic                                            wr_ready,
        input  buf_if_pkg::alloc_req_t                          alloc,
        output logic [buf_cfg_pkg::NUM_CH-1:0][buf_cfg_pkg::CNT_W-1:0] space_free,
        input  buf_if_pkg::drain_req_t [buf_cfg_pkg::NUM_CH-1:0] drain_req,
        output logic [buf_cfg_pkg::NUM_CH-1:0][buf_cfg_pkg::CNT_W-1:0] data_avail,
        input  buf_if_pkg::rd_sel_t                             rd,
        output logic [buf_cfg_pkg::NUM_CH-1:0]                  rd_valid,
        output logic [buf_cfg_pkg::DATA_W-1:0]                  rd_data,
        output logic [buf_cfg_pkg::NUM_CH-1:0]                  dbg_pending,
        output logic [buf_cfg_pkg::NUM_CH-1:0]                  dbg_out_valid
);

        localparam logic [buf_cfg_pkg::CH_ID_W-1:0] ID_LIM =
                buf_cfg_pkg::CH_ID_W'(buf_cfg_pkg::NUM_CH);

        logic                                           wr_id_ok;
        logic                                           al_id_ok;
        logic                                           rd_id_ok;
        logic [buf_cfg_pkg::NUM_CH-1:0]                 wr_en;
        logic [buf_cfg_pkg::NUM_CH-1:0]                 alloc_en;
        logic [buf_cfg_pkg::NUM_CH-1:0]                 pop_en;
        logic [buf_cfg_pkg::NUM_CH-1:0]                 ready_ch;
        logic [buf_cfg_pkg::NUM_CH-1:0][buf_cfg_pkg::DATA_W-1:0] data_ch;

        //==========================================================
        // ID decode, out of range IDs reach no channel
        //==========================================================
        assign wr_id_ok = (wr.ch_id < ID_LIM);
        assign al_id_ok = (alloc.ch_id < ID_LIM);
        assign rd_id_ok = (rd.ch_id < ID_LIM);

        always_comb begin
                wr_en    = '0;
                alloc_en = '0;
                pop_en   = '0;
                if (wr.valid && wr_id_ok)
                        wr_en[wr.ch_id] = 1'b1;
                if (alloc.req && al_id_ok)
                        alloc_en[alloc.ch_id] = 1'b1;
                if (rd.drain && rd_id_ok)
                        pop_en[rd.ch_id] = 1'b1;
        end

        // Return muxes, independent of wr.valid
        always_comb begin
                wr_ready = 1'b0;                        // Invalid ID never ready
                rd_data  = '0;                          // Invalid ID reads zero
                if (wr_id_ok)
                        wr_ready = ready_ch[wr.ch_id];
                if (rd_id_ok)
                        rd_data = data_ch[rd.ch_id];
        end

        //==========================================================
        // Channel units
        //==========================================================
        for (genvar i = 0; i < buf_cfg_pkg::NUM_CH; i++) begin : gen_ch
                chan_unit u_chan (
                        .clk           (clk),
                        .rst           (rst),
                        .wr_en         (wr_en[i]),
                        .wr_data       (wr.data),       // Shared beat bus
                        .wr_ready      (ready_ch[i]),
                        .alloc_en      (alloc_en[i]),
                        .alloc_size    (alloc.size),    // Shared size bus
                        .space_free    (space_free[i]),
                        .drain_req     (drain_req[i]),
                        .data_avail    (data_avail[i]),
                        .pop           (pop_en[i]),
                        .rd_valid      (rd_valid[i]),
                        .rd_data       (data_ch[i]),
                        .dbg_pending   (dbg_pending[i]),
                        .dbg_out_valid (dbg_out_valid[i])
                );
        end

endmodule : buf_ctrl

// File: logic/chan_unit.sv
//==========================================================
// One channel built from FIFO, space tracker and latency bridge
//==========================================================

`timescale 1ns/100ps

module chan_unit (
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            wr_en,          // Decoded write valid
        input  logic [buf_cfg_pkg::DATA_W-1:0]  wr_data,
        output logic                            wr_ready,
        input  logic                            alloc_en,
        input  logic [buf_cfg_pkg::SIZE_W-1:0]  alloc_size,
        output logic [buf_cfg_pkg::CNT_W-1:0]   space_free,
        input  buf_if_pkg::drain_req_t          drain_req,
        output logic [buf_cfg_pkg::CNT_W-1:0]   data_avail,
        input  logic                            pop,            // Decoded drain
        output logic                            rd_valid,
        output logic [buf_cfg_pkg::DATA_W-1:0]  rd_data,
        output logic                            dbg_pending,
        output logic                            dbg_out_valid
);

        localparam logic [buf_cfg_pkg::CNT_W-1:0] DEPTH =
                buf_cfg_pkg::CNT_W'(buf_cfg_pkg::CH_DEPTH);

        logic                           fifo_full;
        logic [buf_cfg_pkg::CNT_W-1:0]  fifo_cnt;
        logic                           fifo_pull;
        logic [buf_cfg_pkg::DATA_W-1:0] fifo_data;
        logic [1:0]                     br_held;
        logic [buf_cfg_pkg::CNT_W-1:0]  stored;
        logic                           wrote;
        logic                           popped;

        // Channel capacity is CH_DEPTH beats across FIFO and bridge
        assign stored = fifo_cnt + buf_cfg_pkg::CNT_W'(br_held)
                        + buf_cfg_pkg::CNT_W'(dbg_pending);
        assign wr_ready      = !fifo_full && (stored < DEPTH);
        assign wrote         = wr_en && wr_ready;
        assign popped        = pop && rd_valid;
        assign dbg_out_valid = rd_valid;

        chan_fifo u_fifo (
                .clk(clk), .rst(rst),
                .push      (wrote),
                .push_data (wr_data),
                .full      (fifo_full),
                .pull      (fifo_pull),         // Driven by the bridge
                .pull_data (fifo_data),
                .count     (fifo_cnt)
        );

        space_tracker u_track (
                .clk(clk), .rst(rst),
                .stored     (stored),
                .alloc_en   (alloc_en),
                .alloc_size (alloc_size),
                .wrote      (wrote),
                .drain_req  (drain_req),
                .popped     (popped),
                .space_free (space_free),
                .data_avail (data_avail)
        );

        latency_bridge u_bridge (
                .clk(clk), .rst(rst),
                .src_nonempty (fifo_cnt != '0),
                .src_pull     (fifo_pull),
                .src_data     (fifo_data),
                .pop          (popped),
                .out_valid    (rd_valid),
                .out_data     (rd_data),
                .held         (br_held),
                .pending      (dbg_pending)
        );

endmodule : chan_unit

// File: logic/latency_bridge.sv
//==========================================================
// Two entry output stage behind the FIFO registered read
// Keeps one pull in flight so pops can run every cycle
//==========================================================

`timescale 1ns/100ps

module latency_bridge (
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            src_nonempty,
        output logic                            src_pull,
        input  logic [buf_cfg_pkg::DATA_W-1:0]  src_data,       // Lands one cycle after pull
        input  logic                            pop,            // Accepted pop only
        output logic                            out_valid,
        output logic [buf_cfg_pkg::DATA_W-1:0]  out_data,
        output logic [1:0]                      held,
        output logic                            pending
);

        buf_if_pkg::bridge_state_e      state;
        logic                           inflight;       // Data arrives on next edge
        logic [1:0]                     occ;            // Beats after this edge
        logic [buf_cfg_pkg::DATA_W-1:0] head;
        logic [buf_cfg_pkg::DATA_W-1:0] tail;

        assign held      = state;
        assign pending   = inflight;
        assign out_valid = (state != buf_if_pkg::BR_EMPTY);
        assign out_data  = head;

        // Count held and in flight beats, credit a pop this cycle
        assign occ      = held + {1'b0, inflight} - {1'b0, pop};
        assign src_pull = src_nonempty && (occ < 2'd2);

        always_ff @(posedge clk) begin
                if (rst) begin
                        state    <= buf_if_pkg::BR_EMPTY;
                        inflight <= 1'b0;
                end else begin
                        inflight <= src_pull;
                        case (state)
                                buf_if_pkg::BR_EMPTY:
                                        if (inflight) state <= buf_if_pkg::BR_ONE;
                                buf_if_pkg::BR_ONE:
                                        if (inflight && !pop)
                                                state <= buf_if_pkg::BR_TWO;
                                        else if (!inflight && pop)
                                                state <= buf_if_pkg::BR_EMPTY;
                                buf_if_pkg::BR_TWO:
                                        if (pop) state <= buf_if_pkg::BR_ONE;  // Never in flight here
                                default: state <= buf_if_pkg::BR_EMPTY;
                        endcase
                end
        end

        // Head always holds the oldest beat
        always_ff @(posedge clk) begin
                case (state)
                        buf_if_pkg::BR_EMPTY: if (inflight) head <= src_data;
                        buf_if_pkg::BR_ONE: begin
                                if (inflight && pop)
                                        head <= src_data;       // Replace popped head
                                else if (inflight)
                                        tail <= src_data;
                        end
                        buf_if_pkg::BR_TWO: if (pop) head <= tail;
                        default: ;
                endcase
        end

endmodule : latency_bridge

// File: logic/space_tracker.sv
//==========================================================
// Write and drain reservation bookkeeping for one channel
//==========================================================

`timescale 1ns/100ps

module space_tracker (
        input  logic                            clk,
        input  logic                            rst,
        input  logic [buf_cfg_pkg::CNT_W-1:0]   stored,         // FIFO plus bridge beats
        input  logic                            alloc_en,
        input  logic [buf_cfg_pkg::SIZE_W-1:0]  alloc_size,
        input  logic                            wrote,          // Accepted write
        input  buf_if_pkg::drain_req_t          drain_req,
        input  logic                            popped,         // Accepted pop
        output logic [buf_cfg_pkg::CNT_W-1:0]   space_free,
        output logic [buf_cfg_pkg::CNT_W-1:0]   data_avail
);

        localparam logic [buf_cfg_pkg::CNT_W:0] DEPTH =
                (buf_cfg_pkg::CNT_W + 1)'(buf_cfg_pkg::CH_DEPTH);

        logic [buf_cfg_pkg::CNT_W-1:0]  wr_resv;        // Space promised to producer
        logic [buf_cfg_pkg::CNT_W-1:0]  dr_resv;        // Data promised to consumer
        logic [buf_cfg_pkg::CNT_W:0]    committed;      // One extra bit for the sum
        logic                           alloc_ok;
        logic                           drain_ok;
        logic                           wr_use;
        logic                           dr_use;

        //==========================================================
        // Reported counts
        //==========================================================
        assign committed  = {1'b0, stored} + {1'b0, wr_resv};
        assign space_free = (committed >= DEPTH) ? '0 :
                            buf_cfg_pkg::CNT_W'(DEPTH - committed);
        assign data_avail = (stored > dr_resv) ? (stored - dr_resv) : '0;

        // Grant only when the request fits
        assign alloc_ok = alloc_en && (alloc_size <= space_free);
        assign drain_ok = drain_req.req && (drain_req.size <= data_avail);

        // Consumption stops at zero
        assign wr_use = wrote  && (wr_resv != '0);
        assign dr_use = popped && (dr_resv != '0);

        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_resv <= '0;
                        dr_resv <= '0;
                end else begin
                        wr_resv <= wr_resv + (alloc_ok ? alloc_size : '0)
                                   - buf_cfg_pkg::CNT_W'(wr_use);
                        dr_resv <= dr_resv + (drain_ok ? drain_req.size : '0)
                                   - buf_cfg_pkg::CNT_W'(dr_use);
                end
        end

endmodule : space_tracker

// File: logic/chan_fifo.sv
//==========================================================
// Per channel synchronous FIFO, read data one cycle after pull
//==========================================================

`timescale 1ns/100ps

module chan_fifo (
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            push,
        input  logic [buf_cfg_pkg::DATA_W-1:0]  push_data,
        output logic                            full,
        input  logic                            pull,
        output logic [buf_cfg_pkg::DATA_W-1:0]  pull_data,      // Registered read
        output logic [buf_cfg_pkg::CNT_W-1:0]   count
);

        localparam logic [buf_cfg_pkg::CNT_W-1:0] FULL_CNT =
                buf_cfg_pkg::CNT_W'(buf_cfg_pkg::CH_DEPTH);

        logic [buf_cfg_pkg::DATA_W-1:0] mem [buf_cfg_pkg::CH_DEPTH];
        logic [buf_cfg_pkg::PTR_W-1:0]  wr_ptr;
        logic [buf_cfg_pkg::PTR_W-1:0]  rd_ptr;
        logic                           do_push;
        logic                           do_pull;

        assign full    = (count == FULL_CNT);
        assign do_push = push && !full;                 // Overflow guard
        assign do_pull = pull && (count != '0);         // Underflow guard

        // Pointers and occupancy
        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (do_push)
                                wr_ptr <= wr_ptr + 1'b1;        // Wraps at CH_DEPTH
                        if (do_pull)
                                rd_ptr <= rd_ptr + 1'b1;
                        case ({do_push, do_pull})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;        // Idle or both
                        endcase
                end
        end

        // Storage array and registered read port
        always_ff @(posedge clk) begin
                if (do_push)
                        mem[wr_ptr] <= push_data;
                if (do_pull)
                        pull_data <= mem[rd_ptr];               // Valid on next cycle
        end

endmodule : chan_fifo

// File: logic/buf_if_pkg.sv
//==========================================================
// Port bundles and bridge state type of the stream buffer
// Structs travel whole between the top level and the channels
//==========================================================

package buf_if_pkg;

        // Producer beat, transfers when valid and wr_ready meet
        typedef struct packed {
                logic                               valid;
                logic [buf_cfg_pkg::CH_ID_W-1:0]    ch_id;
                logic [buf_cfg_pkg::DATA_W-1:0]     data;
        } wr_beat_t;

        // Single cycle space reservation from the producer
        typedef struct packed {
                logic                               req;
                logic [buf_cfg_pkg::CH_ID_W-1:0]    ch_id;
                logic [buf_cfg_pkg::SIZE_W-1:0]     size;
        } alloc_req_t;

        // Consumer pop select
        typedef struct packed {
                logic                               drain;
                logic [buf_cfg_pkg::CH_ID_W-1:0]    ch_id;
        } rd_sel_t;

        // Per channel consumer data reservation
        typedef struct packed {
                logic                               req;
                logic [buf_cfg_pkg::SIZE_W-1:0]     size;
        } drain_req_t;

        // Number of beats parked in the latency bridge
        typedef enum logic [1:0] {
                BR_EMPTY = 2'd0,
                BR_ONE   = 2'd1,
                BR_TWO   = 2'd2
        } bridge_state_e;

endpackage : buf_if_pkg

// File: logic/buf_cfg_pkg.sv
//==========================================================
// Sizing constants for the stream buffer controller
// Referenced by scoped name from every RTL file
//==========================================================

package buf_cfg_pkg;

        //==========================================================
        // Channel organisation
        //==========================================================
        localparam int NUM_CH   = 3;    // Independent stream channels
        localparam int CH_ID_W  = 2;    // ID 3 is decoded as out of range

        //==========================================================
        // Storage sizing
        //==========================================================
        localparam int DATA_W   = 32;   // Beat width
        localparam int CH_DEPTH = 16;   // Beats per channel FIFO
        localparam int PTR_W    = 4;    // Wraps naturally at CH_DEPTH
        localparam int CNT_W    = 5;    // Holds 0 to CH_DEPTH inclusive
        localparam int SIZE_W   = 5;    // Reservation request size

endpackage : buf_cfg_pkg
